/* logic/slot_alloc_pkg.sv */
// Shared widths, register map and response codes, imported by every slot allocator RTL block
`default_nettype none

package slot_alloc_pkg;

  // --------------------------------------------------------------------------
  // Pool geometry
  // --------------------------------------------------------------------------
  // Number of buffer slots managed by the pool
  localparam int NUM_SLOTS = 16;
  // Most slots one request can take in a cycle
  localparam int ALLOCS_PER_CYCLE = 2;

  // One bit per slot, set means free
  typedef logic [NUM_SLOTS-1:0] slot_mask_t;
  // Binary index of a single slot
  typedef logic [$clog2(NUM_SLOTS)-1:0] slot_idx_t;
  // Free count needs one extra code to reach NUM_SLOTS itself
  typedef logic [$clog2(NUM_SLOTS+1)-1:0] slot_count_t;
  // Requested slot count, 1 or 2
  typedef logic [$clog2(ALLOCS_PER_CYCLE+1)-1:0] alloc_count_t;

  // --------------------------------------------------------------------------
  // AXI4-Lite host port
  // --------------------------------------------------------------------------
  typedef logic [7:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0] axil_resp_t;

  // Register byte offsets
  localparam axil_addr_t ADDR_FREE = 8'h00;
  localparam axil_addr_t ADDR_COUNT = 8'h04;
  localparam axil_addr_t ADDR_RELEASE = 8'h08;

  // Response codes used by the slave
  localparam axil_resp_t RESP_OKAY = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage : slot_alloc_pkg

`default_nettype wire

/* logic/enc_priority_encoder.sv */
// Multi-result priority encoder, returns several disjoint one-hot picks from one request vector
`timescale 1ns/1ps
`default_nettype none

module enc_priority_encoder #(
  // Width of the request vector, must exceed num_results
  parameter int num_requesters = 2,
  // Number of one-hot picks produced, at least 1
  parameter int num_results = 1,
  // Set to give the top bit of in the highest priority
  parameter bit msb_highest_priority = 0
) (
  input  logic [num_requesters-1:0]                  in,
  output logic [num_results-1:0][num_requesters-1:0] out
);

  // --------------------------------------------------------------------------
  // LSB-first view of the request vector
  // --------------------------------------------------------------------------
  logic [num_requesters-1:0]                  in_int;
  // Requests still unclaimed when result k searches
  logic [num_results-1:0][num_requesters-1:0] remain;
  // Picks in the LSB-first view
  logic [num_results-1:0][num_requesters-1:0] out_int;

  // Mirror the input when the MSB wins, so the search below is always LSB first
  always_comb begin
    for (int i = 0; i < num_requesters; i++) begin
      if (msb_highest_priority) begin
        in_int[i] = in[num_requesters-1-i];
      end else begin
        in_int[i] = in[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Cascaded lowest-set-bit search
  // --------------------------------------------------------------------------
  for (genvar k = 0; k < num_results; k++) begin : gen_result
    if (k == 0) begin : gen_first
      // First result sees every request
      assign remain[k] = in_int;
    end else begin : gen_next
      // Drop whatever the previous result claimed
      assign remain[k] = remain[k-1] & ~out_int[k-1];
    end

    // Two's complement trick isolates the lowest set bit
    // All zero when nothing is left to claim
    assign out_int[k] = remain[k] & (~remain[k] + 1'b1);
  end

  // --------------------------------------------------------------------------
  // Back to the caller's bit order
  // --------------------------------------------------------------------------
  always_comb begin
    for (int k = 0; k < num_results; k++) begin
      for (int j = 0; j < num_requesters; j++) begin
        if (msb_highest_priority) begin
          out[k][j] = out_int[k][num_requesters-1-j];
        end else begin
          out[k][j] = out_int[k][j];
        end
      end
    end
  end

endmodule : enc_priority_encoder

`default_nettype wire

/* logic/enc_onehot_to_bin.sv */
// One-hot slot pick to binary index converter, one instance per allocation result
`timescale 1ns/1ps
`default_nettype none

module enc_onehot_to_bin (
  input  slot_alloc_pkg::slot_mask_t onehot,
  output slot_alloc_pkg::slot_idx_t  idx,
  output logic                       found
);

  import slot_alloc_pkg::*;

  // OR together the index of each set bit
  // With a legal one-hot input only one term contributes
  always_comb begin
    idx = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (onehot[i]) begin
        idx = idx | slot_idx_t'(i);
      end
    end
  end

  // Any bit set means the encoder found a slot
  // Zero input leaves idx at 0 with found low
  assign found = |onehot;

endmodule : enc_onehot_to_bin

`default_nettype wire

/* logic/slot_pool.sv */
// Free-slot mask and count for the pool, applies grants and host releases and drives alloc_ready
`timescale 1ns/1ps
`default_nettype none

module slot_pool (
  input  logic                       clk,
  input  logic                       arst_n,
  // Allocation request and encoder picks
  input  logic                       alloc_valid,
  input  slot_alloc_pkg::alloc_count_t alloc_count,
  input  slot_alloc_pkg::slot_mask_t [slot_alloc_pkg::ALLOCS_PER_CYCLE-1:0] pick,
  output logic                       alloc_ready,
  // Release pulse from the register slave
  input  logic                       release_valid,
  input  slot_alloc_pkg::slot_mask_t release_mask,
  // Pool status
  output slot_alloc_pkg::slot_mask_t free_mask,
  output slot_alloc_pkg::slot_count_t free_count
);

  import slot_alloc_pkg::*;

  logic        alloc_fire;
  slot_mask_t  alloc_clear;
  slot_mask_t  release_set;
  slot_mask_t  next_mask;
  slot_count_t next_count;

  // --------------------------------------------------------------------------
  // Allocation handshake
  // --------------------------------------------------------------------------
  // Ready straight from the registered count, so a grant never overdraws
  assign alloc_ready = (free_count >= slot_count_t'(alloc_count));
  assign alloc_fire  = alloc_valid && alloc_ready;

  // Bits granted this cycle
  // Second pick only counts for a two-slot request
  always_comb begin
    alloc_clear = '0;
    if (alloc_fire) begin
      if (alloc_count != '0) begin
        alloc_clear = alloc_clear | pick[0];
      end
      if (alloc_count == alloc_count_t'(2)) begin
        alloc_clear = alloc_clear | pick[1];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Next state of the mask
  // --------------------------------------------------------------------------
  // Release only lands during its one-cycle pulse
  assign release_set = release_valid ? release_mask : '0;

  // Grants clear, releases set
  // A slot released while already free just stays free
  assign next_mask = (free_mask & ~alloc_clear) | release_set;

  // Population count of the next mask keeps count and mask in step
  always_comb begin
    next_count = '0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      next_count = next_count + slot_count_t'(next_mask[i]);
    end
  end

  // --------------------------------------------------------------------------
  // State registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Whole pool starts free
      free_mask  <= '1;
      free_count <= slot_count_t'(NUM_SLOTS);
    end else begin
      free_mask  <= next_mask;
      free_count <= next_count;
    end
  end

endmodule : slot_pool

`default_nettype wire

/* logic/slot_axil_regs.sv */
// AXI4-Lite slave for the slot pool, exposes free mask and count and turns release writes into a pulse
`timescale 1ns/1ps
`default_nettype none

module slot_axil_regs (
  input  logic                        clk,
  input  logic                        arst_n,
  // Write address channel
  input  logic                        awvalid,
  output logic                        awready,
  input  slot_alloc_pkg::axil_addr_t  awaddr,
  // Write data channel
  input  logic                        wvalid,
  output logic                        wready,
  input  slot_alloc_pkg::axil_data_t  wdata,
  input  logic [3:0]                  wstrb,
  // Write response channel
  output logic                        bvalid,
  input  logic                        bready,
  output slot_alloc_pkg::axil_resp_t  bresp,
  // Read address channel
  input  logic                        arvalid,
  output logic                        arready,
  input  slot_alloc_pkg::axil_addr_t  araddr,
  // Read data channel
  output logic                        rvalid,
  input  logic                        rready,
  output slot_alloc_pkg::axil_data_t  rdata,
  output slot_alloc_pkg::axil_resp_t  rresp,
  // Pool side
  input  slot_alloc_pkg::slot_mask_t  free_mask,
  input  slot_alloc_pkg::slot_count_t free_count,
  output logic                        release_valid,
  output slot_alloc_pkg::slot_mask_t  release_mask
);

  import slot_alloc_pkg::*;

  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } wr_state_t;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;
  logic      wr_accept;
  logic      wr_hit;
  logic      rd_accept;

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------
  // Address and data taken together, never while a response is still open
  assign wr_accept = (wr_state == WR_IDLE) && awvalid && wvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign bvalid    = (wr_state == WR_RESP);

  // Only the release register is writable
  assign wr_hit = (awaddr == ADDR_RELEASE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state      <= WR_IDLE;
      release_valid <= 1'b0;
    end else begin
      // Pulse lines up with the first bvalid cycle
      release_valid <= wr_accept && wr_hit;
      case (wr_state)
        WR_IDLE: begin
          if (wr_accept) begin
            wr_state <= WR_RESP;
          end
        end
        WR_RESP: begin
          // Response held until the host takes it
          if (bready) begin
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // Response code and release payload captured at acceptance
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      // Byte lanes 0 and 1 cover the 16 slot bits
      release_mask[7:0]  <= wstrb[0] ? wdata[7:0] : 8'h00;
      release_mask[15:8] <= wstrb[1] ? wdata[15:8] : 8'h00;
    end
  end

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------
  // New address only once the previous data has gone
  assign rd_accept = (rd_state == RD_IDLE) && arvalid;
  assign arready   = rd_accept;
  assign rvalid    = (rd_state == RD_DATA);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (rd_accept) begin
            rd_state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (rready) begin
            rd_state <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // Snapshot of pool status at address acceptance
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      case (araddr)
        ADDR_FREE: begin
          rdata <= axil_data_t'(free_mask);
          rresp <= RESP_OKAY;
        end
        ADDR_COUNT: begin
          rdata <= axil_data_t'(free_count);
          rresp <= RESP_OKAY;
        end
        // Write-only register reads back as zero
        ADDR_RELEASE: begin
          rdata <= '0;
          rresp <= RESP_OKAY;
        end
        default: begin
          rdata <= '0;
          rresp <= RESP_SLVERR;
        end
      endcase
    end
  end

endmodule : slot_axil_regs

`default_nettype wire

/* logic/slot_alloc_top.sv */
// Slot allocator top level, wires the AXI4-Lite register slave, pool, encoder and index converters
`timescale 1ns/1ps
`default_nettype none

module slot_alloc_top (
  input  logic                         clk,
  input  logic                         arst_n,
  // Allocation port
  input  logic                         alloc_valid,
  input  slot_alloc_pkg::alloc_count_t alloc_count,
  output logic                         alloc_ready,
  output slot_alloc_pkg::slot_idx_t    alloc_slot0,
  output slot_alloc_pkg::slot_idx_t    alloc_slot1,
  output logic                         alloc_found1,
  // AXI4-Lite host port
  input  logic                         awvalid,
  output logic                         awready,
  input  slot_alloc_pkg::axil_addr_t   awaddr,
  input  logic                         wvalid,
  output logic                         wready,
  input  slot_alloc_pkg::axil_data_t   wdata,
  input  logic [3:0]                   wstrb,
  output logic                         bvalid,
  input  logic                         bready,
  output slot_alloc_pkg::axil_resp_t   bresp,
  input  logic                         arvalid,
  output logic                         arready,
  input  slot_alloc_pkg::axil_addr_t   araddr,
  output logic                         rvalid,
  input  logic                         rready,
  output slot_alloc_pkg::axil_data_t   rdata,
  output slot_alloc_pkg::axil_resp_t   rresp
);

  import slot_alloc_pkg::*;

  // Pool status and release handoff
  slot_mask_t  free_mask;
  slot_count_t free_count;
  logic        release_valid;
  slot_mask_t  release_mask;
  // Lowest free slots, one one-hot vector per result
  slot_mask_t [ALLOCS_PER_CYCLE-1:0] pick;

  // --------------------------------------------------------------------------
  // Host registers
  // --------------------------------------------------------------------------
  slot_axil_regs u_regs (
    .clk(clk), .arst_n(arst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .free_mask(free_mask), .free_count(free_count),
    .release_valid(release_valid), .release_mask(release_mask)
  );

  // --------------------------------------------------------------------------
  // Pool state and allocation datapath
  // --------------------------------------------------------------------------
  slot_pool u_pool (
    .clk(clk), .arst_n(arst_n),
    .alloc_valid(alloc_valid), .alloc_count(alloc_count),
    .pick(pick), .alloc_ready(alloc_ready),
    .release_valid(release_valid), .release_mask(release_mask),
    .free_mask(free_mask), .free_count(free_count)
  );

  // LSB first so the lowest free index always wins
  enc_priority_encoder #(
    .num_requesters(NUM_SLOTS),
    .num_results(ALLOCS_PER_CYCLE),
    .msb_highest_priority(1'b0)
  ) u_enc (
    .in(free_mask),
    .out(pick)
  );

  // First pick is always present when alloc_ready is high
  enc_onehot_to_bin u_idx0 (.onehot(pick[0]), .idx(alloc_slot0), .found());

  // Second pick may be missing with only one slot free
  enc_onehot_to_bin u_idx1 (.onehot(pick[1]), .idx(alloc_slot1), .found(alloc_found1));

endmodule : slot_alloc_top

`default_nettype wire

/* verification/tb_slot_alloc.sv */
// Self-checking testbench for the slot allocator, compiled from flist.f with tb_slot_alloc as top
`timescale 1ns/1ps
`default_nettype none

module tb_slot_alloc;

  import slot_alloc_pkg::*;

  // About 300 cycles of tests, so this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic         clk;
  logic         arst_n;
  logic         alloc_valid;
  alloc_count_t alloc_count;
  logic         alloc_ready;
  slot_idx_t    alloc_slot0;
  slot_idx_t    alloc_slot1;
  logic         alloc_found1;
  logic         awvalid;
  logic         awready;
  axil_addr_t   awaddr;
  logic         wvalid;
  logic         wready;
  axil_data_t   wdata;
  logic [3:0]   wstrb;
  logic         bvalid;
  logic         bready;
  axil_resp_t   bresp;
  logic         arvalid;
  logic         arready;
  axil_addr_t   araddr;
  logic         rvalid;
  logic         rready;
  axil_data_t   rdata;
  axil_resp_t   rresp;

  // Reference free mask, set bit means free
  slot_mask_t  model_mask;
  logic [31:0] lfsr_state;
  int          error_count;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;

  slot_alloc_top dut0 (
    .clk(clk), .arst_n(arst_n),
    .alloc_valid(alloc_valid), .alloc_count(alloc_count), .alloc_ready(alloc_ready),
    .alloc_slot0(alloc_slot0), .alloc_slot1(alloc_slot1), .alloc_found1(alloc_found1),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model helpers
  // --------------------------------------------------------------------------
  function automatic int count_free(input slot_mask_t mask);
    int n;
    n = 0;
    for (int i = 0; i < NUM_SLOTS; i++) begin
      n += int'(mask[i]);
    end
    return n;
  endfunction

  // Walk up from slot 0, first free one wins
  function automatic slot_idx_t lowest_free(input slot_mask_t mask);
    for (int i = 0; i < NUM_SLOTS; i++) begin
      if (mask[i]) begin
        return slot_idx_t'(i);
      end
    end
    return '0;
  endfunction

  function automatic slot_idx_t second_free(input slot_mask_t mask);
    return lowest_free(mask & ~(slot_mask_t'(1) << lowest_free(mask)));
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Ready tracks the model count every cycle
  assert property (@(posedge clk) disable iff (!arst_n)
    alloc_ready == (count_free(model_mask) >= int'(alloc_count)))
  else begin
    error_count++;
    $display("[ERROR] %0t: alloc_ready does not match %0d free slots", $time,
             count_free(model_mask));
  end

  // Granted indices are the lowest free ones of the model
  assert property (@(posedge clk) disable iff (!arst_n)
    (alloc_valid && alloc_ready) |-> (alloc_slot0 == lowest_free(model_mask)) &&
    (alloc_count != 2'd2 || (alloc_found1 && alloc_slot1 == second_free(model_mask))))
  else begin
    error_count++;
    $display("[ERROR] %0t: granted slots %0d/%0d, expected %0d/%0d", $time,
             alloc_slot0, alloc_slot1, lowest_free(model_mask), second_free(model_mask));
  end

  task automatic compare_value(input string what, input longint got, input longint exp);
    assert (got == exp)
    else begin
      error_count++;
      $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name,
               error_count - errors_at_start);
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus and request tasks
  // --------------------------------------------------------------------------
  task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                           output axil_resp_t resp);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    bready  <= 1'b1;
    do @(negedge clk); while (!(awready && wready));
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(negedge clk); while (!bvalid);
    resp = bresp;
    // Release lands on this edge, together with the response handshake
    @(posedge clk);
    bready <= 1'b0;
    if (addr == ADDR_RELEASE) begin
      model_mask <= model_mask | data[NUM_SLOTS-1:0];
    end
    @(negedge clk);
  endtask

  task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
                          output axil_resp_t resp);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    rready  <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
    @(negedge clk);
  endtask

  // Holds the request until ready, then clears the predicted slots in the model
  task automatic request_slots(input int count, output slot_idx_t slot0,
                               output slot_idx_t slot1, output logic found1);
    slot_mask_t next_mask;
    @(posedge clk);
    alloc_valid <= 1'b1;
    alloc_count <= alloc_count_t'(count);
    do @(negedge clk); while (!alloc_ready);
    slot0  = alloc_slot0;
    slot1  = alloc_slot1;
    found1 = alloc_found1;
    next_mask = model_mask & ~(slot_mask_t'(1) << lowest_free(model_mask));
    if (count == 2) begin
      next_mask = next_mask & ~(slot_mask_t'(1) << lowest_free(next_mask));
    end
    @(posedge clk);
    alloc_valid <= 1'b0;
    model_mask  <= next_mask;
    @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Run limit
  // --------------------------------------------------------------------------
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    slot_idx_t   s0;
    slot_idx_t   s1;
    logic        f1;
    axil_data_t  data;
    axil_resp_t  resp;
    logic [31:0] bits;
    slot_mask_t  rel;
    slot_mask_t  held;
    int          errs;
    int          cnt;
    arst_n = 1'b0;
    alloc_valid = 1'b0;
    alloc_count = 2'd1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = 4'h0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    model_mask = '1;
    lfsr_state = 32'hc451;
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    // Whole pool free after reset
    errs = error_count;
    read_reg(ADDR_FREE, data, resp);
    compare_value("free mask after reset", data, 32'h0000_ffff);
    compare_value("free mask response", resp, RESP_OKAY);
    read_reg(ADDR_COUNT, data, resp);
    compare_value("free count after reset", data, NUM_SLOTS);
    compare_value("free count response", resp, RESP_OKAY);
    report_test("reset state", errs);

    // Singles come out in index order
    errs = error_count;
    for (int i = 0; i < 6; i++) begin
      request_slots(1, s0, s1, f1);
      compare_value("single grant index", s0, i);
      read_reg(ADDR_COUNT, data, resp);
      compare_value("free count after grant", data, NUM_SLOTS - 1 - i);
    end
    report_test("single allocations", errs);

    // Holes at 1, 3 and 4 give a fragmented mask
    errs = error_count;
    write_reg(ADDR_RELEASE, 32'h0000_001a, resp);
    compare_value("release response", resp, RESP_OKAY);
    for (int i = 0; i < 4; i++) begin
      request_slots(2, s0, s1, f1);
      compare_value("second slot found", f1, 1);
      compare_value("distinct slots", s0 != s1, 1);
    end
    report_test("double allocations", errs);

    // Drain to one free slot, then hold a double request
    errs = error_count;
    while (count_free(model_mask) > 1) begin
      request_slots(1, s0, s1, f1);
    end
    held = model_mask;
    fork
      request_slots(2, s0, s1, f1);
      begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_value("alloc_ready while short", alloc_ready, 0);
        read_reg(ADDR_FREE, data, resp);
        compare_value("free mask while held", data, held);
        write_reg(ADDR_RELEASE, 32'h0000_0001, resp);
      end
    join
    compare_value("held grant index", s0, 0);
    read_reg(ADDR_COUNT, data, resp);
    compare_value("free count after held grant", data, 0);
    report_test("back-pressure", errs);

    // Random releases into an empty pool, then random requests drain it
    errs = error_count;
    for (int round = 0; round < 3; round++) begin
      take_bits(NUM_SLOTS, bits);
      rel = bits[NUM_SLOTS-1:0];
      if (rel == '0) begin
        rel = 16'h8000;
      end
      write_reg(ADDR_RELEASE, axil_data_t'(rel), resp);
      compare_value("random release response", resp, RESP_OKAY);
      read_reg(ADDR_FREE, data, resp);
      compare_value("free mask after release", data, rel);
      request_slots(1, s0, s1, f1);
      compare_value("lowest released slot", s0, lowest_free(rel));
      while (count_free(model_mask) > 0) begin
        take_bits(1, bits);
        cnt = (count_free(model_mask) >= 2 && bits[0]) ? 2 : 1;
        request_slots(cnt, s0, s1, f1);
      end
    end
    // Unmapped offsets answer with an error and leave the pool alone
    write_reg(8'h0c, 32'h0000_ffff, resp);
    compare_value("unmapped write response", resp, RESP_SLVERR);
    read_reg(ADDR_FREE, data, resp);
    compare_value("free mask after unmapped write", data, model_mask);
    read_reg(8'h10, data, resp);
    compare_value("unmapped read response", resp, RESP_SLVERR);
    compare_value("unmapped read data", data, 0);
    read_reg(ADDR_RELEASE, data, resp);
    compare_value("release register readback", data, 0);
    compare_value("release readback response", resp, RESP_OKAY);
    report_test("random releases", errs);

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_slot_alloc

`default_nettype wire

/* flist.f */
logic/slot_alloc_pkg.sv
logic/enc_priority_encoder.sv
logic/enc_onehot_to_bin.sv
logic/slot_pool.sv
logic/slot_axil_regs.sv
logic/slot_alloc_top.sv
verification/tb_slot_alloc.sv

/* run.sh */
#!/bin/sh
# Build the slot allocator testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_slot_alloc \
  -f flist.f -o sim_slot_alloc && ./obj_dir/sim_slot_alloc > sim.log 2>&1 || true
cat sim.log 2>/dev/null
test -s sim.log && ! grep -q "TEST FAIL" sim.log && echo "Simulation passed" && exit 0
echo "Simulation failed"
exit 1
